// File: rtl/mem_pkg.sv
// memory access package with operation and state encodings, widths and credit limit
`default_nettype none

package mem_pkg;

  // data and address width
  localparam int DATA_W = 32;
  // destination register index width
  localparam int REG_ADDR_W = 5;
  // byte lanes on the memory bus
  localparam int SEL_W = 4;

  // credits granted by memory after reset
  localparam int CREDIT_MAX = 2;
  localparam int CREDIT_W = $clog2(CREDIT_MAX + 1);
  localparam logic [CREDIT_W-1:0] CREDIT_INIT = CREDIT_W'(CREDIT_MAX);

  // bit 3 marks a store
  typedef enum logic [3:0] {
    LB  = 4'h0,
    LBU = 4'h1,
    LH  = 4'h2,
    LHU = 4'h3,
    LW  = 4'h4,
    SB  = 4'h8,
    SH  = 4'h9,
    SW  = 4'ha
  } mem_op_e;

  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    ISSUE     = 2'd1,
    WAIT_RESP = 2'd2,
    WRITEBACK = 2'd3
  } mem_state_e;

endpackage

`default_nettype wire

// File: rtl/mem_lane_if.sv
// lane interface carrying the held operation and address offset to the lane logic
`timescale 1ns/1ps
`default_nettype none

interface mem_lane_if;

  // registered operation of the request in flight
  mem_pkg::mem_op_e op;
  // low address bits pick the byte lanes
  logic [1:0] addr_low;
  // size and offset disagree
  logic misaligned;

  modport fsm (
    output op,
    output addr_low,
    input  misaligned
  );

  // both lane blocks read op and offset, only the store decode drives misaligned
  modport lane (
    input  op,
    input  addr_low,
    output misaligned
  );

endinterface

`default_nettype wire

// File: rtl/mem_credit_counter.sv
// credit counter tracking how many bus requests memory can still accept
`timescale 1ns/1ps
`default_nettype none

module mem_credit_counter (
  input  wire  mem_addr_read_ready,
  input  wire  mem_re_o,
  input  wire  spend_i,
  input  wire  return_i,
  output logic credit_avail_o
);

  logic [mem_pkg::CREDIT_W-1:0] count_q;

  // a spend and a return in the same cycle cancel
  always_ff @(posedge mem_addr_read_ready or negedge mem_re_o)
  begin
    if (!mem_re_o)
    begin
      count_q <= mem_pkg::CREDIT_INIT;
    end
    else if (spend_i && !return_i)
    begin
      count_q <= count_q - 1'b1;
    end
    else if (return_i && !spend_i)
    begin
      count_q <= count_q + 1'b1;
    end
  end

  assign credit_avail_o = (count_q != '0);

  // memory never hands back a credit that was not spent
  a_no_overflow: assert property (@(posedge mem_addr_read_ready) disable iff (!mem_re_o)
    return_i |-> (count_q != mem_pkg::CREDIT_INIT))
    else $error("credit returned while count is full");

  // the sequencer only spends what it holds
  a_no_underflow: assert property (@(posedge mem_addr_read_ready) disable iff (!mem_re_o)
    spend_i |-> (count_q != '0))
    else $error("credit spent at zero");

endmodule

`default_nettype wire

// File: rtl/mem_access_fsm.sv
// access sequencer that takes a request, spends a credit, waits for memory and writes back
`timescale 1ns/1ps
`default_nettype none

module mem_access_fsm (
  input  wire                                mem_addr_read_ready,
  input  wire                                mem_re_o,
  input  wire                                req_valid_i,
  input  mem_pkg::mem_op_e                   req_op_i,
  input  wire  [mem_pkg::DATA_W-1:0]         req_addr_i,
  input  wire  [mem_pkg::DATA_W-1:0]         req_wdata_i,
  input  wire  [mem_pkg::REG_ADDR_W-1:0]     req_rd_i,
  input  wire                                credit_avail_i,
  input  wire                                bus_rdata_valid_i,
  input  wire                                bus_wr_ack_i,
  input  wire  [mem_pkg::DATA_W-1:0]         aligned_load_i,
  output logic                               req_ready_o,
  output logic                               bus_req_o,
  output logic                               bus_we_o,
  output logic [mem_pkg::DATA_W-1:0]         bus_addr_o,
  output logic [mem_pkg::DATA_W-1:0]         store_word_o,
  output logic                               wb_valid_o,
  output logic                               wb_we_o,
  output logic [mem_pkg::REG_ADDR_W-1:0]     wb_rd_o,
  output logic [mem_pkg::DATA_W-1:0]         wb_data_o,
  output logic                               wb_err_o,
  mem_lane_if.fsm                            lane
);

  mem_pkg::mem_state_e state_q;
  mem_pkg::mem_state_e state_d;

  mem_pkg::mem_op_e                op_q;
  logic [mem_pkg::DATA_W-1:0]      addr_q;
  logic [mem_pkg::DATA_W-1:0]      wdata_q;
  logic [mem_pkg::REG_ADDR_W-1:0]  rd_q;
  logic [mem_pkg::DATA_W-1:0]      wb_data_q;
  logic                            is_store;
  logic                            resp_done;

  assign is_store  = op_q inside {mem_pkg::SB, mem_pkg::SH, mem_pkg::SW};
  // loads finish on read data, stores on the write ack
  assign resp_done = is_store ? bus_wr_ack_i : bus_rdata_valid_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      mem_pkg::IDLE:
      begin
        if (req_valid_i)
        begin
          state_d = mem_pkg::ISSUE;
        end
      end
      mem_pkg::ISSUE:
      begin
        // misaligned skips the bus entirely
        if (lane.misaligned)
        begin
          state_d = mem_pkg::WRITEBACK;
        end
        else if (credit_avail_i)
        begin
          state_d = mem_pkg::WAIT_RESP;
        end
      end
      mem_pkg::WAIT_RESP:
      begin
        if (resp_done)
        begin
          state_d = mem_pkg::WRITEBACK;
        end
      end
      default:
      begin
        state_d = mem_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge mem_addr_read_ready or negedge mem_re_o)
  begin
    if (!mem_re_o)
    begin
      state_q <= mem_pkg::IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // request payload and load result
  always_ff @(posedge mem_addr_read_ready)
  begin
    if (req_valid_i && req_ready_o)
    begin
      op_q      <= req_op_i;
      addr_q    <= req_addr_i;
      wdata_q   <= req_wdata_i;
      rd_q      <= req_rd_i;
      wb_data_q <= '0;
    end
    else if ((state_q == mem_pkg::WAIT_RESP) && bus_rdata_valid_i)
    begin
      wb_data_q <= aligned_load_i;
    end
  end

  assign lane.op       = op_q;
  assign lane.addr_low = addr_q[1:0];

  assign req_ready_o  = (state_q == mem_pkg::IDLE);
  assign bus_req_o    = (state_q == mem_pkg::ISSUE) && credit_avail_i && !lane.misaligned;
  assign bus_we_o     = is_store;
  assign bus_addr_o   = addr_q;
  assign store_word_o = wdata_q;

  assign wb_valid_o = (state_q == mem_pkg::WRITEBACK);
  assign wb_we_o    = wb_valid_o && !is_store && !lane.misaligned;
  assign wb_err_o   = wb_valid_o && lane.misaligned;
  assign wb_rd_o    = rd_q;
  assign wb_data_o  = wb_data_q;

  // one pulse per request, always followed by the wait for memory
  a_req_in_issue: assert property (@(posedge mem_addr_read_ready) disable iff (!mem_re_o)
    bus_req_o |-> (state_q == mem_pkg::ISSUE) ##1 (state_q == mem_pkg::WAIT_RESP))
    else $error("bus request outside issue");

  // memory only answers a request that is outstanding
  a_resp_in_wait: assert property (@(posedge mem_addr_read_ready) disable iff (!mem_re_o)
    (bus_rdata_valid_i || bus_wr_ack_i) |-> (state_q == mem_pkg::WAIT_RESP))
    else $error("response strobe outside wait");

endmodule

`default_nettype wire

// File: rtl/store_lane_decode.sv
// store lane decode producing byte enables, replicated store data and the alignment check
`timescale 1ns/1ps
`default_nettype none

module store_lane_decode (
  input  wire  [mem_pkg::DATA_W-1:0] wdata_i,
  output logic [mem_pkg::SEL_W-1:0]  sel_o,
  output logic [mem_pkg::DATA_W-1:0] store_word_o,
  mem_lane_if.lane                   lane
);

  logic [mem_pkg::SEL_W-1:0] byte_sel;
  logic [mem_pkg::SEL_W-1:0] half_sel;

  // one lane per byte offset
  assign byte_sel = mem_pkg::SEL_W'(1) << lane.addr_low;
  // low or high pair
  assign half_sel = lane.addr_low[1] ? 4'b1100 : 4'b0011;

  always_comb
  begin
    sel_o           = 4'b1111;
    store_word_o    = '0;
    lane.misaligned = 1'b0;
    case (lane.op)
      mem_pkg::LB, mem_pkg::LBU:
      begin
        sel_o = byte_sel;
      end
      mem_pkg::SB:
      begin
        sel_o        = byte_sel;
        store_word_o = {4{wdata_i[7:0]}};
      end
      mem_pkg::LH, mem_pkg::LHU:
      begin
        sel_o           = half_sel;
        lane.misaligned = lane.addr_low[0];
      end
      mem_pkg::SH:
      begin
        sel_o           = half_sel;
        store_word_o    = {2{wdata_i[15:0]}};
        lane.misaligned = lane.addr_low[0];
      end
      mem_pkg::SW:
      begin
        store_word_o    = wdata_i;
        lane.misaligned = (lane.addr_low != 2'b00);
      end
      default:
      begin
        // LW, full word
        lane.misaligned = (lane.addr_low != 2'b00);
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/load_data_align.sv
// load aligner that picks the addressed byte or halfword and extends it
`timescale 1ns/1ps
`default_nettype none

module load_data_align (
  input  wire  [mem_pkg::DATA_W-1:0] rdata_i,
  output logic [mem_pkg::DATA_W-1:0] load_o,
  mem_lane_if.lane                   lane
);

  logic [7:0]  byte_val;
  logic [15:0] half_val;

  // byte lane from the offset, half from bit 1
  assign byte_val = rdata_i[8*lane.addr_low +: 8];
  assign half_val = rdata_i[16*lane.addr_low[1] +: 16];

  always_comb
  begin
    case (lane.op)
      mem_pkg::LB:
      begin
        load_o = {{24{byte_val[7]}}, byte_val};
      end
      mem_pkg::LBU:
      begin
        load_o = {24'h0, byte_val};
      end
      mem_pkg::LH:
      begin
        load_o = {{16{half_val[15]}}, half_val};
      end
      mem_pkg::LHU:
      begin
        load_o = {16'h0, half_val};
      end
      mem_pkg::LW:
      begin
        load_o = rdata_i;
      end
      default:
      begin
        // stores write nothing back
        load_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/mem_stage_top.sv
// memory stage top joining sequencer, credit counter and lane logic
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top (
  input  wire                                mem_addr_read_ready,
  input  wire                                mem_re_o,
  input  wire                                req_valid_i,
  input  mem_pkg::mem_op_e                   req_op_i,
  input  wire  [mem_pkg::DATA_W-1:0]         req_addr_i,
  input  wire  [mem_pkg::DATA_W-1:0]         req_wdata_i,
  input  wire  [mem_pkg::REG_ADDR_W-1:0]     req_rd_i,
  input  wire                                credit_return_i,
  input  wire  [mem_pkg::DATA_W-1:0]         bus_rdata_i,
  input  wire                                bus_rdata_valid_i,
  input  wire                                bus_wr_ack_i,
  output logic                               req_ready_o,
  output logic                               bus_req_o,
  output logic                               bus_we_o,
  output logic [mem_pkg::DATA_W-1:0]         bus_addr_o,
  output logic [mem_pkg::SEL_W-1:0]          bus_sel_o,
  output logic [mem_pkg::DATA_W-1:0]         bus_wdata_o,
  output logic                               wb_valid_o,
  output logic                               wb_we_o,
  output logic [mem_pkg::REG_ADDR_W-1:0]     wb_rd_o,
  output logic [mem_pkg::DATA_W-1:0]         wb_data_o,
  output logic                               wb_err_o
);

  logic                       credit_avail;
  logic [mem_pkg::DATA_W-1:0] store_word;
  logic [mem_pkg::DATA_W-1:0] aligned_load;

  mem_lane_if lane_if ();

  mem_access_fsm u_fsm (
    .mem_addr_read_ready (mem_addr_read_ready),
    .mem_re_o            (mem_re_o),
    .req_valid_i         (req_valid_i),
    .req_op_i            (req_op_i),
    .req_addr_i          (req_addr_i),
    .req_wdata_i         (req_wdata_i),
    .req_rd_i            (req_rd_i),
    .credit_avail_i      (credit_avail),
    .bus_rdata_valid_i   (bus_rdata_valid_i),
    .bus_wr_ack_i        (bus_wr_ack_i),
    .aligned_load_i      (aligned_load),
    .req_ready_o         (req_ready_o),
    .bus_req_o           (bus_req_o),
    .bus_we_o            (bus_we_o),
    .bus_addr_o          (bus_addr_o),
    .store_word_o        (store_word),
    .wb_valid_o          (wb_valid_o),
    .wb_we_o             (wb_we_o),
    .wb_rd_o             (wb_rd_o),
    .wb_data_o           (wb_data_o),
    .wb_err_o            (wb_err_o),
    .lane                (lane_if.fsm)
  );

  // every bus request spends one credit
  mem_credit_counter u_credit (
    .mem_addr_read_ready (mem_addr_read_ready),
    .mem_re_o            (mem_re_o),
    .spend_i             (bus_req_o),
    .return_i            (credit_return_i),
    .credit_avail_o      (credit_avail)
  );

  store_lane_decode u_store (
    .wdata_i      (store_word),
    .sel_o        (bus_sel_o),
    .store_word_o (bus_wdata_o),
    .lane         (lane_if.lane)
  );

  load_data_align u_load (
    .rdata_i (bus_rdata_i),
    .load_o  (aligned_load),
    .lane    (lane_if.lane)
  );

endmodule

`default_nettype wire

// File: sim/mem_stage_checker.sv
// scoreboard for the memory stage that compares bus and writeback events with the current row
`timescale 1ns/1ps
`default_nettype none

module mem_stage_checker (
  input  wire                            mem_addr_read_ready,
  input  wire                            mem_re_o,
  input  mem_pkg::mem_op_e               exp_op_i,
  input  wire [mem_pkg::DATA_W-1:0]      exp_addr_i,
  input  wire [mem_pkg::DATA_W-1:0]      exp_wdata_i,
  input  wire [mem_pkg::REG_ADDR_W-1:0]  exp_rd_i,
  input  wire [mem_pkg::DATA_W-1:0]      exp_data_i,
  input  wire                            exp_err_i,
  input  wire [mem_pkg::SEL_W-1:0]       exp_sel_i,
  input  wire                            req_ready_i,
  input  wire                            bus_req_i,
  input  wire                            bus_we_i,
  input  wire [mem_pkg::DATA_W-1:0]      bus_addr_i,
  input  wire [mem_pkg::SEL_W-1:0]       bus_sel_i,
  input  wire [mem_pkg::DATA_W-1:0]      bus_wdata_i,
  input  wire                            credit_return_i,
  input  wire                            wb_valid_i,
  input  wire                            wb_we_i,
  input  wire [mem_pkg::REG_ADDR_W-1:0]  wb_rd_i,
  input  wire [mem_pkg::DATA_W-1:0]      wb_data_i,
  input  wire                            wb_err_i,
  output int                             test_count_o,
  output int                             error_count_o
);

  int   tests_done = 0;
  int   errors = 0;
  int   row_errors = 0;
  int   req_seen = 0;
  // requests sent to memory whose credit has not come back yet
  int   outstanding = 0;
  logic wb_prev = 1'b0;
  logic exp_store;
  logic exp_we;

  assign exp_store     = exp_op_i inside {mem_pkg::SB, mem_pkg::SH, mem_pkg::SW};
  assign exp_we        = !exp_store && !exp_err_i;
  assign test_count_o  = tests_done;
  assign error_count_o = errors;

  task report_failure(input string msg);
    $display("error in test %0d: %s", tests_done, msg);
    row_errors++;
    errors++;
  endtask

  task compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      row_errors++;
      errors++;
    end
  endtask

  // sampled mid-cycle where all outputs are settled
  always @(negedge mem_addr_read_ready)
  begin
    if (!mem_re_o)
    begin
      if (!req_ready_i || bus_req_i || wb_valid_i || wb_we_i || wb_err_i)
      begin
        report_failure("outputs not at their reset values during reset");
      end
    end
    else
    begin
      if (bus_req_i)
      begin
        req_seen++;
        if (outstanding >= mem_pkg::CREDIT_MAX)
        begin
          report_failure("bus request issued while no credit was held");
        end
        if (exp_err_i)
        begin
          report_failure("bus request issued for a misaligned access");
        end
        compare_value("bus_addr_o", bus_addr_i, exp_addr_i);
        compare_value("bus_we_o", 32'(bus_we_i), 32'(exp_store));
        compare_value("bus_sel_o", 32'(bus_sel_i), 32'(exp_sel_i));
        if (exp_store)
        begin
          compare_value("bus_wdata_o", bus_wdata_i, exp_wdata_i);
        end
      end
      outstanding = outstanding + (bus_req_i ? 1 : 0) - (credit_return_i ? 1 : 0);

      if (wb_valid_i)
      begin
        if (wb_prev)
        begin
          report_failure("wb_valid_o stayed high for more than one cycle");
        end
        if (req_seen != (exp_err_i ? 0 : 1))
        begin
          report_failure("wrong number of bus requests for this access");
        end
        compare_value("wb_err_o", 32'(wb_err_i), 32'(exp_err_i));
        compare_value("wb_we_o", 32'(wb_we_i), 32'(exp_we));
        compare_value("wb_data_o", wb_data_i, exp_data_i);
        if (exp_we)
        begin
          compare_value("wb_rd_o", 32'(wb_rd_i), 32'(exp_rd_i));
        end
        $display("test %0d %s addr %h: %s", tests_done, exp_op_i.name(), exp_addr_i,
                 (row_errors == 0) ? "ok" : "failed");
        tests_done++;
        row_errors = 0;
        req_seen   = 0;
      end
      wb_prev = wb_valid_i;
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_mem_stage.sv
// testbench for the memory stage with a stimulus table, a delayed memory model and a timeout
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

  localparam int NUM_ROWS       = 26;
  localparam int RESET_CYCLES   = 5;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 20 + RESET_CYCLES;
  // extra cycles the memory sits on a credit for the back-pressure rows
  localparam int HOLD_CYCLES    = 10;

  typedef struct packed {
    mem_pkg::mem_op_e                op;
    logic [mem_pkg::DATA_W-1:0]      addr;
    logic [mem_pkg::DATA_W-1:0]      wdata;
    logic [mem_pkg::REG_ADDR_W-1:0]  rd;
    logic [mem_pkg::DATA_W-1:0]      exp_data;
    logic                            exp_err;
    logic [mem_pkg::SEL_W-1:0]       exp_sel;
    logic [mem_pkg::DATA_W-1:0]      exp_wdata;
    logic                            hold;
  } row_t;

  logic mem_addr_read_ready;
  logic mem_re_o;
  logic req_valid_i;
  mem_pkg::mem_op_e req_op_i;
  logic [mem_pkg::DATA_W-1:0]     req_addr_i;
  logic [mem_pkg::DATA_W-1:0]     req_wdata_i;
  logic [mem_pkg::REG_ADDR_W-1:0] req_rd_i;
  logic credit_return_i;
  logic [mem_pkg::DATA_W-1:0]     bus_rdata_i;
  logic bus_rdata_valid_i;
  logic bus_wr_ack_i;
  logic req_ready_o;
  logic bus_req_o;
  logic bus_we_o;
  logic [mem_pkg::DATA_W-1:0]     bus_addr_o;
  logic [mem_pkg::SEL_W-1:0]      bus_sel_o;
  logic [mem_pkg::DATA_W-1:0]     bus_wdata_o;
  logic wb_valid_o;
  logic wb_we_o;
  logic [mem_pkg::REG_ADDR_W-1:0] wb_rd_o;
  logic [mem_pkg::DATA_W-1:0]     wb_data_o;
  logic wb_err_o;

  row_t       table_rows [0:NUM_ROWS-1];
  logic [4:0] cur_row;
  row_t       cur;
  int         test_count;
  int         error_count;
  int         cycle_count;

  // memory model state
  logic [31:0] mem_words [0:15];
  logic        resp_busy;
  int          resp_wait;
  logic        resp_we;
  logic [31:0] resp_addr;
  logic [31:0] resp_wdata;
  logic [3:0]  resp_sel;
  int          credit_timers [$];
  int          ret_idx;

  assign cur = table_rows[cur_row];

  mem_stage_top uut (
    .mem_addr_read_ready (mem_addr_read_ready),
    .mem_re_o            (mem_re_o),
    .req_valid_i         (req_valid_i),
    .req_op_i            (req_op_i),
    .req_addr_i          (req_addr_i),
    .req_wdata_i         (req_wdata_i),
    .req_rd_i            (req_rd_i),
    .credit_return_i     (credit_return_i),
    .bus_rdata_i         (bus_rdata_i),
    .bus_rdata_valid_i   (bus_rdata_valid_i),
    .bus_wr_ack_i        (bus_wr_ack_i),
    .req_ready_o         (req_ready_o),
    .bus_req_o           (bus_req_o),
    .bus_we_o            (bus_we_o),
    .bus_addr_o          (bus_addr_o),
    .bus_sel_o           (bus_sel_o),
    .bus_wdata_o         (bus_wdata_o),
    .wb_valid_o          (wb_valid_o),
    .wb_we_o             (wb_we_o),
    .wb_rd_o             (wb_rd_o),
    .wb_data_o           (wb_data_o),
    .wb_err_o            (wb_err_o)
  );

  mem_stage_checker u_checker (
    .mem_addr_read_ready (mem_addr_read_ready),
    .mem_re_o            (mem_re_o),
    .exp_op_i            (cur.op),
    .exp_addr_i          (cur.addr),
    .exp_wdata_i         (cur.exp_wdata),
    .exp_rd_i            (cur.rd),
    .exp_data_i          (cur.exp_data),
    .exp_err_i           (cur.exp_err),
    .exp_sel_i           (cur.exp_sel),
    .req_ready_i         (req_ready_o),
    .bus_req_i           (bus_req_o),
    .bus_we_i            (bus_we_o),
    .bus_addr_i          (bus_addr_o),
    .bus_sel_i           (bus_sel_o),
    .bus_wdata_i         (bus_wdata_o),
    .credit_return_i     (credit_return_i),
    .wb_valid_i          (wb_valid_o),
    .wb_we_i             (wb_we_o),
    .wb_rd_i             (wb_rd_o),
    .wb_data_i           (wb_data_o),
    .wb_err_i            (wb_err_o),
    .test_count_o        (test_count),
    .error_count_o       (error_count)
  );

  task automatic put_row(input int idx, input mem_pkg::mem_op_e op, input logic [31:0] addr,
                         input logic [31:0] wdata, input int rd, input logic [31:0] data,
                         input int err, input int sel, input logic [31:0] bus_word,
                         input int hold);
    table_rows[5'(idx)] = {op, addr, wdata, 5'(rd), data, 1'(err), 4'(sel), bus_word, 1'(hold)};
  endtask

  initial
  begin
    mem_addr_read_ready = 1'b0;
    forever #20 mem_addr_read_ready = ~mem_addr_read_ready;
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge mem_addr_read_ready);
      cycle_count++;
    end
    $display("timeout: no completion after %0d cycles", cycle_count);
    $display("RESULT: FAIL");
    $finish;
  end

  // memory answers after 1 to 4 cycles, then returns the credit after 1 to 3 more
  initial
  begin
    void'($urandom(32'h867a_ba1d));
    bus_rdata_i       <= '0;
    bus_rdata_valid_i <= 1'b0;
    bus_wr_ack_i      <= 1'b0;
    credit_return_i   <= 1'b0;
    resp_busy = 1'b0;
    resp_wait = 0;
    for (int w = 0; w < 16; w++)
    begin
      mem_words[4'(w)] = 32'h5a00_0000 ^ (32'(w) * 32'h0001_0203);
    end
    forever
    begin
      @(posedge mem_addr_read_ready);
      bus_rdata_valid_i <= 1'b0;
      bus_wr_ack_i      <= 1'b0;
      credit_return_i   <= 1'b0;
      ret_idx = -1;
      for (int k = 0; k < credit_timers.size(); k++)
      begin
        if (credit_timers[k] > 0)
        begin
          credit_timers[k]--;
        end
        if (credit_timers[k] == 0 && ret_idx < 0)
        begin
          ret_idx = k;
        end
      end
      // one credit per cycle at most
      if (ret_idx >= 0)
      begin
        credit_return_i <= 1'b1;
        credit_timers.delete(ret_idx);
      end
      if (resp_busy)
      begin
        resp_wait--;
        if (resp_wait == 0)
        begin
          resp_busy = 1'b0;
          if (resp_we)
          begin
            for (int b = 0; b < 4; b++)
            begin
              if (resp_sel[2'(b)])
              begin
                mem_words[resp_addr[5:2]][8*b +: 8] = resp_wdata[8*b +: 8];
              end
            end
            bus_wr_ack_i <= 1'b1;
          end
          else
          begin
            bus_rdata_i       <= mem_words[resp_addr[5:2]];
            bus_rdata_valid_i <= 1'b1;
          end
          credit_timers.push_back(int'($urandom_range(3, 1)) + (cur.hold ? HOLD_CYCLES : 0));
        end
      end
      if (bus_req_o)
      begin
        resp_busy  = 1'b1;
        resp_wait  = int'($urandom_range(4, 1));
        resp_we    = bus_we_o;
        resp_addr  = bus_addr_o;
        resp_wdata = bus_wdata_o;
        resp_sel   = bus_sel_o;
      end
    end
  end

  initial
  begin
    // idx op addr wdata rd exp_data err sel bus_wdata hold
    put_row(0,  mem_pkg::SW,  'h10, 'hdeadbeef, 1,  'h0,        0, 'hf, 'hdeadbeef, 0);
    put_row(1,  mem_pkg::LW,  'h10, 'h0,        2,  'hdeadbeef, 0, 'hf, 'h0,        0);
    put_row(2,  mem_pkg::SB,  'h20, 'h00000081, 3,  'h0,        0, 'h1, 'h81818181, 0);
    put_row(3,  mem_pkg::SB,  'h21, 'h00000092, 3,  'h0,        0, 'h2, 'h92929292, 0);
    put_row(4,  mem_pkg::SB,  'h22, 'h000000a3, 3,  'h0,        0, 'h4, 'ha3a3a3a3, 0);
    put_row(5,  mem_pkg::SB,  'h23, 'h777777b4, 3,  'h0,        0, 'h8, 'hb4b4b4b4, 0);
    put_row(6,  mem_pkg::LB,  'h20, 'h0,        4,  'hffffff81, 0, 'h1, 'h0,        0);
    put_row(7,  mem_pkg::LBU, 'h21, 'h0,        5,  'h00000092, 0, 'h2, 'h0,        0);
    put_row(8,  mem_pkg::LB,  'h22, 'h0,        6,  'hffffffa3, 0, 'h4, 'h0,        0);
    put_row(9,  mem_pkg::LBU, 'h23, 'h0,        7,  'h000000b4, 0, 'h8, 'h0,        0);
    put_row(10, mem_pkg::LBU, 'h20, 'h0,        8,  'h00000081, 0, 'h1, 'h0,        0);
    put_row(11, mem_pkg::LB,  'h23, 'h0,        9,  'hffffffb4, 0, 'h8, 'h0,        0);
    put_row(12, mem_pkg::SH,  'h30, 'h12348421, 10, 'h0,        0, 'h3, 'h84218421, 0);
    put_row(13, mem_pkg::SH,  'h32, 'h0000f00d, 10, 'h0,        0, 'hc, 'hf00df00d, 0);
    put_row(14, mem_pkg::LH,  'h30, 'h0,        11, 'hffff8421, 0, 'h3, 'h0,        0);
    put_row(15, mem_pkg::LHU, 'h32, 'h0,        12, 'h0000f00d, 0, 'hc, 'h0,        0);
    put_row(16, mem_pkg::LHU, 'h30, 'h0,        13, 'h00008421, 0, 'h3, 'h0,        0);
    put_row(17, mem_pkg::LH,  'h32, 'h0,        14, 'hfffff00d, 0, 'hc, 'h0,        0);
    put_row(18, mem_pkg::LH,  'h31, 'h0,        15, 'h0,        1, 'h0, 'h0,        0);
    put_row(19, mem_pkg::LW,  'h12, 'h0,        16, 'h0,        1, 'h0, 'h0,        0);
    put_row(20, mem_pkg::SW,  'h13, 'h01020304, 16, 'h0,        1, 'h0, 'h0,        0);
    put_row(21, mem_pkg::LW,  'h20, 'h0,        17, 'hb4a39281, 0, 'hf, 'h0,        0);
    // memory sits on these credits so the third request stalls in issue
    put_row(22, mem_pkg::SW,  'h04, 'h11223344, 18, 'h0,        0, 'hf, 'h11223344, 1);
    put_row(23, mem_pkg::SW,  'h08, 'h55667788, 18, 'h0,        0, 'hf, 'h55667788, 1);
    put_row(24, mem_pkg::LW,  'h04, 'h0,        19, 'h11223344, 0, 'hf, 'h0,        1);
    put_row(25, mem_pkg::LW,  'h08, 'h0,        20, 'h55667788, 0, 'hf, 'h0,        0);

    mem_re_o    <= 1'b0;
    req_valid_i <= 1'b0;
    req_op_i    <= mem_pkg::LW;
    req_addr_i  <= '0;
    req_wdata_i <= '0;
    req_rd_i    <= '0;
    cur_row     <= '0;
    repeat (RESET_CYCLES) @(posedge mem_addr_read_ready);
    mem_re_o <= 1'b1;

    for (int r = 0; r < NUM_ROWS; r++)
    begin
      cur_row     <= 5'(r);
      req_valid_i <= 1'b1;
      req_op_i    <= table_rows[5'(r)].op;
      req_addr_i  <= table_rows[5'(r)].addr;
      req_wdata_i <= table_rows[5'(r)].wdata;
      req_rd_i    <= table_rows[5'(r)].rd;
      @(posedge mem_addr_read_ready);
      while (!req_ready_o)
      begin
        @(posedge mem_addr_read_ready);
      end
      req_valid_i <= 1'b0;
      @(posedge mem_addr_read_ready);
      while (!wb_valid_o)
      begin
        @(posedge mem_addr_read_ready);
      end
    end

    $display("tests run %0d of %0d, errors %0d", test_count, NUM_ROWS, error_count);
    if (error_count == 0 && test_count == NUM_ROWS)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
rtl/mem_pkg.sv
rtl/mem_lane_if.sv
rtl/mem_credit_counter.sv
rtl/mem_access_fsm.sv
rtl/store_lane_decode.sv
rtl/load_data_align.sv
rtl/mem_stage_top.sv
sim/mem_stage_checker.sv
sim/tb_mem_stage.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_mem_stage -f sim.f -o tb_mem_stage
out=$(./obj_dir/tb_mem_stage) || true
echo "$out"
if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
